//--- rtl/rider_status_pkg.sv
package rider_status_pkg;

  // Firmware revision, reported in register 0
  localparam logic [7:0] major_rev = 8'd1;
  localparam logic [7:0] minor_rev = 8'd4;
  localparam logic [7:0] build_rev = 8'd2;

  localparam int unsigned num_status_regs = 19;  // Mapped addresses 0 to 18
  localparam int unsigned reg_width       = 32;  // Status words and counters

  // Register map, 19 to 31 unmapped
  typedef enum logic [4:0] {
    REG_VERSION     = 5'd0,   // Firmware version
    REG_ERROR       = 5'd1,   // Error and warning flags
    REG_EXT_CLK     = 5'd2,   // External clock
    REG_CLK_SYNTH   = 5'd3,   // Clock synthesizer
    REG_DAQ_LINK    = 5'd4,
    REG_TTC_TTS     = 5'd5,
    REG_FSM_STATE0  = 5'd6,
    REG_FSM_STATE1  = 5'd7,
    REG_ACQ         = 5'd8,   // Acquisition setup
    REG_TRIG_INFO   = 5'd9,
    REG_TRIG_NUM    = 5'd10,
    REG_TRIG_TS_LSB = 5'd11,
    REG_TRIG_TS_MSB = 5'd12,
    REG_DC_THRES    = 5'd13,  // Data corruption
    REG_DC_COUNT    = 5'd14,
    REG_UT_THRES    = 5'd15,  // Unknown TTC command
    REG_UT_COUNT    = 5'd16,
    REG_DO_THRES    = 5'd17,  // DDR3 overflow
    REG_DO_COUNT    = 5'd18
  } reg_addr_e;

  // Decoded bus request
  typedef enum logic [1:0] {
    OP_NONE        = 2'd0,
    OP_READ        = 2'd1,
    OP_WRITE_THRES = 2'd2,  // Threshold load
    OP_CLEAR_COUNT = 2'd3   // Count and flag clear
  } bus_op_e;

endpackage

//--- rtl/reg_access_decode.sv
module reg_access_decode
  import rider_status_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr_en,
  input  logic                 rd_en,
  input  logic [4:0]           addr,
  input  logic [reg_width-1:0] wdata,
  output bus_op_e              op,
  output reg_addr_e            op_addr,
  output logic [reg_width-1:0] wr_value,
  output logic                 dc_thres_wr,
  output logic                 dc_count_clr,
  output logic                 ut_thres_wr,
  output logic                 ut_count_clr,
  output logic                 do_thres_wr,
  output logic                 do_count_clr
);

  bus_op_e op_nxt;
  logic [5:0] wr_nxt;  // {do_clr, do_thr, ut_clr, ut_thr, dc_clr, dc_thr}

  // Classify the request, write beats read
  always_comb begin
    op_nxt = OP_NONE;
    wr_nxt = '0;
    if (wr_en) begin
      case (reg_addr_e'(addr))
        REG_DC_THRES: begin
          op_nxt    = OP_WRITE_THRES;
          wr_nxt[0] = 1'b1;
        end
        REG_DC_COUNT: begin
          op_nxt    = OP_CLEAR_COUNT;
          wr_nxt[1] = 1'b1;
        end
        REG_UT_THRES: begin
          op_nxt    = OP_WRITE_THRES;
          wr_nxt[2] = 1'b1;
        end
        REG_UT_COUNT: begin
          op_nxt    = OP_CLEAR_COUNT;
          wr_nxt[3] = 1'b1;
        end
        REG_DO_THRES: begin
          op_nxt    = OP_WRITE_THRES;
          wr_nxt[4] = 1'b1;
        end
        REG_DO_COUNT: begin
          op_nxt    = OP_CLEAR_COUNT;
          wr_nxt[5] = 1'b1;
        end
        default: op_nxt = OP_NONE;  // Read-only or unmapped, ignored
      endcase
    end else if (rd_en) begin
      op_nxt = OP_READ;  // Mapping checked in status stage
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      op           <= OP_NONE;
      dc_thres_wr  <= 1'b0;
      dc_count_clr <= 1'b0;
      ut_thres_wr  <= 1'b0;
      ut_count_clr <= 1'b0;
      do_thres_wr  <= 1'b0;
      do_count_clr <= 1'b0;
    end else begin
      op           <= op_nxt;
      dc_thres_wr  <= wr_nxt[0];
      dc_count_clr <= wr_nxt[1];
      ut_thres_wr  <= wr_nxt[2];
      ut_count_clr <= wr_nxt[3];
      do_thres_wr  <= wr_nxt[4];
      do_count_clr <= wr_nxt[5];
    end
  end

  // Address and data ride along with op
  always_ff @(posedge clk) begin
    op_addr <= reg_addr_e'(addr);
    if (wr_en) wr_value <= wdata;  // Shared by all counters
  end

endmodule

//--- rtl/soft_error_counter.sv
module soft_error_counter
  import rider_status_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 event_in,   // One-cycle pulse
  input  logic                 thres_wr,   // Load threshold from wr_value
  input  logic                 count_clr,  // Zero count and flag
  input  logic [reg_width-1:0] wr_value,
  output logic [reg_width-1:0] count,
  output logic [reg_width-1:0] thres,
  output logic                 flag
);

  logic thres_hit;

  // Zero threshold disables the flag
  assign thres_hit = (thres != '0) && (count >= thres);

  // Event count, wraps at full scale
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (count_clr) begin
      count <= '0;  // Clear beats a same-cycle event
    end else if (event_in) begin
      count <= count + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      thres <= '0;
    end else if (thres_wr) begin
      thres <= wr_value;
    end
  end

  // Sticky until cleared, one edge behind the count
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      flag <= 1'b0;
    end else if (count_clr) begin
      flag <= 1'b0;
    end else if (thres_hit) begin
      flag <= 1'b1;
    end
  end

endmodule

//--- rtl/status_reg_block.sv
module status_reg_block
  import rider_status_pkg::*;
#(
  parameter int unsigned num_chan = 5
) (
  input  logic                 clk,
  input  logic                 arst_n,
  input  bus_op_e              op,
  input  reg_addr_e            op_addr,
  // Soft error counters
  input  logic [reg_width-1:0] dc_count,
  input  logic [reg_width-1:0] dc_thres,
  input  logic                 dc_flag,
  input  logic [reg_width-1:0] ut_count,
  input  logic [reg_width-1:0] ut_thres,
  input  logic                 ut_flag,
  input  logic [reg_width-1:0] do_count,
  input  logic [reg_width-1:0] do_thres,
  input  logic                 do_flag,
  // Board status
  input  logic                 prog_chan_done,
  input  logic                 error_trig_num_from_tt,
  input  logic                 error_trig_type_from_tt,
  input  logic                 error_trig_num_from_cm,
  input  logic                 error_trig_type_from_cm,
  input  logic                 error_pll_unlock,
  input  logic                 error_trig_rate,
  input  logic [num_chan-1:0]  chan_error_rc,
  input  logic                 daq_clk_sel,
  input  logic                 daq_clk_en,
  input  logic                 adcclk_clkin0_stat,
  input  logic                 adcclk_clkin1_stat,
  input  logic                 adcclk_stat_ld,
  input  logic                 adcclk_stat,
  input  logic                 daq_almost_full,
  input  logic                 daq_ready,
  input  logic [3:0]           tts_state,
  input  logic [5:0]           ttc_chan_b_info,
  input  logic                 ttc_ready,
  input  logic [30:0]          cm_state,
  input  logic [3:0]           ttr_state,
  input  logic [3:0]           cac_state,
  input  logic [6:0]           tp_state,
  input  logic [4:0]           acq_readout_pause,
  input  logic [1:0]           fill_type,
  input  logic [num_chan-1:0]  chan_en,
  input  logic                 endianness_sel,
  input  logic                 trig_fifo_full,
  input  logic                 acq_fifo_full,
  input  logic [3:0]           trig_delay,
  input  logic [7:0]           trig_settings,
  input  logic [23:0]          trig_num,
  input  logic [43:0]          trig_timestamp,
  // Read return
  output logic [reg_width-1:0] rd_data,
  output logic                 rd_valid,
  output logic                 rd_error
);

  logic [reg_width-1:0] status_word [num_status_regs];
  logic                 addr_mapped;
  logic [reg_width-1:0] sel_word;

  always_comb begin
    status_word[REG_VERSION]     = {1'b0, prog_chan_done, 6'd0, major_rev, minor_rev, build_rev};
    // Error flags, DDR3 warning sits just above the channel errors
    status_word[REG_ERROR]       = {{(reg_width - 9 - num_chan){1'b0}}, do_flag, chan_error_rc,
                                    error_trig_type_from_cm, error_trig_type_from_tt,
                                    error_trig_num_from_cm, error_trig_num_from_tt,
                                    dc_flag, error_trig_rate, ut_flag, error_pll_unlock};
    status_word[REG_EXT_CLK]     = {30'd0, daq_clk_sel, daq_clk_en};
    status_word[REG_CLK_SYNTH]   = {28'd0, adcclk_clkin1_stat, adcclk_clkin0_stat,
                                    adcclk_stat_ld, adcclk_stat};
    status_word[REG_DAQ_LINK]    = {30'd0, daq_almost_full, daq_ready};
    status_word[REG_TTC_TTS]     = {21'd0, tts_state, ttc_chan_b_info, ttc_ready};
    status_word[REG_FSM_STATE0]  = {1'b0, cm_state};
    status_word[REG_FSM_STATE1]  = {17'd0, tp_state, cac_state, ttr_state};
    status_word[REG_ACQ]         = {{(reg_width - 8 - num_chan){1'b0}}, endianness_sel,
                                    acq_readout_pause, fill_type, chan_en};
    status_word[REG_TRIG_INFO]   = {18'd0, trig_settings, acq_fifo_full, trig_fifo_full,
                                    trig_delay};
    status_word[REG_TRIG_NUM]    = {8'd0, trig_num};
    status_word[REG_TRIG_TS_LSB] = trig_timestamp[31:0];
    status_word[REG_TRIG_TS_MSB] = {20'd0, trig_timestamp[43:32]};
    // Counter side
    status_word[REG_DC_THRES]    = dc_thres;
    status_word[REG_DC_COUNT]    = dc_count;
    status_word[REG_UT_THRES]    = ut_thres;
    status_word[REG_UT_COUNT]    = ut_count;
    status_word[REG_DO_THRES]    = do_thres;
    status_word[REG_DO_COUNT]    = do_count;
  end

  // Unmapped reads return zero
  assign addr_mapped = 32'(op_addr) < num_status_regs;
  assign sel_word    = addr_mapped ? status_word[op_addr] : '0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_valid <= 1'b0;
      rd_error <= 1'b0;
    end else begin
      rd_valid <= (op == OP_READ);
      rd_error <= (op == OP_READ) && !addr_mapped;
    end
  end

  // Word captured in the status stage
  always_ff @(posedge clk) begin
    if (op == OP_READ) rd_data <= sel_word;
  end

endmodule

//--- rtl/rider_status.sv
module rider_status
  import rider_status_pkg::*;
#(
  parameter int unsigned num_chan = 5
) (
  input  logic                 clk,
  input  logic                 arst_n,
  // Register bus
  input  logic                 wr_en,
  input  logic                 rd_en,
  input  logic [4:0]           addr,
  input  logic [reg_width-1:0] wdata,
  output logic [reg_width-1:0] rd_data,
  output logic                 rd_valid,
  output logic                 rd_error,
  // Soft error events
  input  logic                 ev_data_corrupt,
  input  logic                 ev_unknown_ttc,
  input  logic                 ev_ddr3_overflow,
  output logic                 error_data_corrupt,
  output logic                 error_unknown_ttc,
  output logic                 ddr3_overflow_warning,
  // Board status
  input  logic                 prog_chan_done,
  input  logic                 error_trig_num_from_tt,
  input  logic                 error_trig_type_from_tt,
  input  logic                 error_trig_num_from_cm,
  input  logic                 error_trig_type_from_cm,
  input  logic                 error_pll_unlock,
  input  logic                 error_trig_rate,
  input  logic [num_chan-1:0]  chan_error_rc,
  input  logic                 daq_clk_sel,
  input  logic                 daq_clk_en,
  input  logic                 adcclk_clkin0_stat,
  input  logic                 adcclk_clkin1_stat,
  input  logic                 adcclk_stat_ld,
  input  logic                 adcclk_stat,
  input  logic                 daq_almost_full,
  input  logic                 daq_ready,
  input  logic [3:0]           tts_state,
  input  logic [5:0]           ttc_chan_b_info,
  input  logic                 ttc_ready,
  input  logic [30:0]          cm_state,
  input  logic [3:0]           ttr_state,
  input  logic [3:0]           cac_state,
  input  logic [6:0]           tp_state,
  input  logic [4:0]           acq_readout_pause,
  input  logic [1:0]           fill_type,
  input  logic [num_chan-1:0]  chan_en,
  input  logic                 endianness_sel,
  input  logic                 trig_fifo_full,
  input  logic                 acq_fifo_full,
  input  logic [3:0]           trig_delay,
  input  logic [7:0]           trig_settings,
  input  logic [23:0]          trig_num,
  input  logic [43:0]          trig_timestamp
);

  bus_op_e              op;
  reg_addr_e            op_addr;
  logic [reg_width-1:0] wr_value;
  logic                 dc_thres_wr, dc_count_clr;
  logic                 ut_thres_wr, ut_count_clr;
  logic                 do_thres_wr, do_count_clr;
  logic [reg_width-1:0] dc_count, dc_thres;
  logic [reg_width-1:0] ut_count, ut_thres;
  logic [reg_width-1:0] do_count, do_thres;

  reg_access_decode u_decode (
    .clk, .arst_n, .wr_en, .rd_en, .addr, .wdata,
    .op, .op_addr, .wr_value,
    .dc_thres_wr, .dc_count_clr,
    .ut_thres_wr, .ut_count_clr,
    .do_thres_wr, .do_count_clr
  );

  // Data corruption
  soft_error_counter u_dc_cnt (
    .clk, .arst_n, .event_in(ev_data_corrupt),
    .thres_wr(dc_thres_wr), .count_clr(dc_count_clr), .wr_value,
    .count(dc_count), .thres(dc_thres), .flag(error_data_corrupt)
  );

  // Unknown TTC command
  soft_error_counter u_ut_cnt (
    .clk, .arst_n, .event_in(ev_unknown_ttc),
    .thres_wr(ut_thres_wr), .count_clr(ut_count_clr), .wr_value,
    .count(ut_count), .thres(ut_thres), .flag(error_unknown_ttc)
  );

  // DDR3 overflow, reported as a warning
  soft_error_counter u_do_cnt (
    .clk, .arst_n, .event_in(ev_ddr3_overflow),
    .thres_wr(do_thres_wr), .count_clr(do_count_clr), .wr_value,
    .count(do_count), .thres(do_thres), .flag(ddr3_overflow_warning)
  );

  status_reg_block #(.num_chan(num_chan)) u_status (
    .clk, .arst_n, .op, .op_addr,
    .dc_count, .dc_thres, .dc_flag(error_data_corrupt),
    .ut_count, .ut_thres, .ut_flag(error_unknown_ttc),
    .do_count, .do_thres, .do_flag(ddr3_overflow_warning),
    .prog_chan_done,
    .error_trig_num_from_tt, .error_trig_type_from_tt,
    .error_trig_num_from_cm, .error_trig_type_from_cm,
    .error_pll_unlock, .error_trig_rate, .chan_error_rc,
    .daq_clk_sel, .daq_clk_en,
    .adcclk_clkin0_stat, .adcclk_clkin1_stat, .adcclk_stat_ld, .adcclk_stat,
    .daq_almost_full, .daq_ready,
    .tts_state, .ttc_chan_b_info, .ttc_ready,
    .cm_state, .ttr_state, .cac_state, .tp_state,
    .acq_readout_pause, .fill_type, .chan_en, .endianness_sel,
    .trig_fifo_full, .acq_fifo_full, .trig_delay, .trig_settings,
    .trig_num, .trig_timestamp,
    .rd_data, .rd_valid, .rd_error
  );

endmodule

//--- bench/rider_status_assert.sv
module rider_status_assert
  import rider_status_pkg::*;
(
  input logic                 clk,
  input logic                 arst_n,
  input logic                 wr_en,
  input logic                 rd_en,
  input logic                 rd_valid,
  input logic                 rd_error,
  input logic [reg_width-1:0] rd_data,
  input logic                 error_data_corrupt,
  input logic                 error_unknown_ttc,
  input logic                 ddr3_overflow_warning,
  input logic                 dc_count_clr,
  input logic                 ut_count_clr,
  input logic                 do_count_clr
);

  int unsigned fail_count = 0;  // Read by the bench at the end

  // Fixed two-edge read latency
  rd_latency: assert property (@(posedge clk) disable iff (!arst_n)
    rd_en && !wr_en |-> ##2 rd_valid)
    else begin
      fail_count++;
      $error("rd_valid did not follow rd_en by two cycles");
    end

  rd_error_zero: assert property (@(posedge clk) disable iff (!arst_n)
    rd_error |-> rd_data == '0)
    else begin
      fail_count++;
      $error("rd_data not zero with rd_error");
    end

  // Sticky flags drop only after a count clear
  dc_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(error_data_corrupt) |-> $past(dc_count_clr))
    else begin
      fail_count++;
      $error("data corruption flag fell without a clear");
    end

  ut_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(error_unknown_ttc) |-> $past(ut_count_clr))
    else begin
      fail_count++;
      $error("unknown TTC flag fell without a clear");
    end

  do_sticky: assert property (@(posedge clk) disable iff (!arst_n)
    $fell(ddr3_overflow_warning) |-> $past(do_count_clr))
    else begin
      fail_count++;
      $error("DDR3 overflow warning fell without a clear");
    end

endmodule

//--- bench/rider_status_checker.sv
module rider_status_checker
  import rider_status_pkg::*;
(
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 wr_en,
  input  logic                 rd_en,
  input  logic [4:0]           addr,
  input  logic [reg_width-1:0] exp_word,  // Prediction for the read now on the bus
  input  logic                 exp_err,
  input  logic [reg_width-1:0] rd_data,
  input  logic                 rd_valid,
  input  logic                 rd_error,
  input  logic                 flag_chk,  // Compare flag ports this cycle
  input  logic [2:0]           flags,     // {do, ut, dc}
  input  logic [2:0]           exp_flags,
  output int                   n_checks,
  output int                   n_errors,
  output int                   in_flight
);

  logic [reg_width+5:0] rd_q [$];  // {err, addr, word} per read in flight
  logic [reg_width+5:0] head;
  int checks = 0;
  int errors = 0;
  int depth  = 0;

  assign n_checks  = checks;
  assign n_errors  = errors;
  assign in_flight = depth;

  // Negedge sampling, all DUT outputs settled
  always @(negedge clk) begin
    if (arst_n) begin
      if (rd_valid) begin
        if (rd_q.size() == 0) begin
          errors++;
          $display("Extra rd_valid at time %0t with no read outstanding", $time);
        end else begin
          head = rd_q.pop_front();  // Oldest read returns first
          checks++;
          if (rd_data !== head[reg_width-1:0] || rd_error !== head[reg_width+5]) begin
            errors++;
            $display("[ERROR] %0t: read of address %0d gave %h err %b, expected %h err %b",
                     $time, head[reg_width+4:reg_width], rd_data, rd_error,
                     head[reg_width-1:0], head[reg_width+5]);
          end
        end
      end
      if (rd_en && !wr_en) rd_q.push_back({exp_err, addr, exp_word});  // Write wins
      if (flag_chk) begin
        checks++;
        if (flags !== exp_flags) begin
          errors++;
          $display("[ERROR] %0t: flag ports %b, expected %b", $time, flags, exp_flags);
        end
      end
      depth = rd_q.size();
    end
  end

endmodule

//--- bench/tb_rider_status.sv
module tb_rider_status
  import rider_status_pkg::*;
();

  localparam int unsigned num_chan    = 5;
  localparam int          status_bits = 162 + 2 * num_chan;  // All status inputs
  localparam int          budget      = 60 + 60 + 120 + 200 + 100 + 60;  // Cycles per test

  logic clk, arst_n, wr_en, rd_en, rd_valid, rd_error;
  logic [4:0] addr;
  logic [reg_width-1:0] wdata, rd_data;
  logic ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow;
  logic error_data_corrupt, error_unknown_ttc, ddr3_overflow_warning;
  logic prog_chan_done, error_trig_num_from_tt, error_trig_type_from_tt, error_trig_num_from_cm;
  logic error_trig_type_from_cm, error_pll_unlock, error_trig_rate, daq_clk_sel, daq_clk_en;
  logic adcclk_clkin0_stat, adcclk_clkin1_stat, adcclk_stat_ld, adcclk_stat;
  logic daq_almost_full, daq_ready, ttc_ready, endianness_sel, trig_fifo_full, acq_fifo_full;
  logic [num_chan-1:0] chan_error_rc, chan_en;
  logic [3:0] tts_state, ttr_state, cac_state, trig_delay;
  logic [5:0] ttc_chan_b_info;
  logic [30:0] cm_state;
  logic [6:0] tp_state;
  logic [4:0] acq_readout_pause;
  logic [1:0] fill_type;
  logic [7:0] trig_settings;
  logic [23:0] trig_num;
  logic [43:0] trig_timestamp;
  logic [reg_width-1:0] exp_word;
  logic exp_err, flag_chk;
  logic [2:0] exp_flags, m_flag;  // Model flags {do, ut, dc}
  logic [reg_width-1:0] m_count [3];
  logic [reg_width-1:0] m_thres [3];
  int n_checks, n_errors, in_flight, prev_checks, prev_errors;
  integer seed;

  initial clk = 1'b0;
  always #5 clk = ~clk;

  rider_status #(.num_chan(num_chan)) dut0 (.*);

  rider_status_checker u_check (
    .clk, .arst_n, .wr_en, .rd_en, .addr, .exp_word, .exp_err,
    .rd_data, .rd_valid, .rd_error, .flag_chk, .exp_flags,
    .flags({ddr3_overflow_warning, error_unknown_ttc, error_data_corrupt}),
    .n_checks, .n_errors, .in_flight
  );

  bind rider_status rider_status_assert u_assert (
    .clk, .arst_n, .wr_en, .rd_en, .rd_valid, .rd_error, .rd_data,
    .error_data_corrupt, .error_unknown_ttc, .ddr3_overflow_warning,
    .dc_count_clr, .ut_count_clr, .do_count_clr
  );

  // Registers 13 to 18 pair up as threshold then count
  function automatic int counter_of(input logic [4:0] a);
    return (int'(a) - int'(REG_DC_THRES)) / 2;
  endfunction

  // Expected word from the register map
  function automatic logic [reg_width-1:0] pack_status(input logic [4:0] a);
    logic [reg_width-1:0] w;
    w = '0;
    case (a)
      REG_VERSION: begin
        w[23:0] = {major_rev, minor_rev, build_rev};
        w[30]   = prog_chan_done;
      end
      REG_ERROR: begin
        w[0] = error_pll_unlock;
        w[1] = m_flag[1];
        w[2] = error_trig_rate;
        w[3] = m_flag[0];
        w[7:4] = {error_trig_type_from_cm, error_trig_type_from_tt,
                  error_trig_num_from_cm, error_trig_num_from_tt};
        w[8 +: num_chan]  = chan_error_rc;
        w[8 + num_chan]   = m_flag[2];  // DDR3 warning above channel errors
      end
      REG_EXT_CLK:     w[1:0] = {daq_clk_sel, daq_clk_en};
      REG_CLK_SYNTH:   w[3:0] = {adcclk_clkin1_stat, adcclk_clkin0_stat,
                                 adcclk_stat_ld, adcclk_stat};
      REG_DAQ_LINK:    w[1:0] = {daq_almost_full, daq_ready};
      REG_TTC_TTS:     w[10:0] = {tts_state, ttc_chan_b_info, ttc_ready};
      REG_FSM_STATE0:  w[30:0] = cm_state;
      REG_FSM_STATE1:  w[14:0] = {tp_state, cac_state, ttr_state};
      REG_ACQ: begin
        w[0 +: num_chan]        = chan_en;
        w[num_chan +: 2]        = fill_type;
        w[num_chan + 2 +: 5]    = acq_readout_pause;
        w[num_chan + 7]         = endianness_sel;
      end
      REG_TRIG_INFO:   w[13:0] = {trig_settings, acq_fifo_full, trig_fifo_full, trig_delay};
      REG_TRIG_NUM:    w[23:0] = trig_num;
      REG_TRIG_TS_LSB: w = trig_timestamp[31:0];
      REG_TRIG_TS_MSB: w[11:0] = trig_timestamp[43:32];
      default: begin
        if (a >= REG_DC_THRES && a <= REG_DO_COUNT)
          w = a[0] ? m_thres[counter_of(a)] : m_count[counter_of(a)];  // Odd is threshold
      end
    endcase
    return w;
  endfunction

  task automatic apply_status(input logic [status_bits-1:0] v);
    {prog_chan_done, error_trig_num_from_tt, error_trig_type_from_tt, error_trig_num_from_cm,
     error_trig_type_from_cm, error_pll_unlock, error_trig_rate, daq_clk_sel, daq_clk_en,
     adcclk_clkin0_stat, adcclk_clkin1_stat, adcclk_stat_ld, adcclk_stat, daq_almost_full,
     daq_ready, ttc_ready, endianness_sel, trig_fifo_full, acq_fifo_full, chan_error_rc,
     chan_en, tts_state, ttc_chan_b_info, cm_state, ttr_state, cac_state, tp_state,
     acq_readout_pause, fill_type, trig_delay, trig_settings, trig_num, trig_timestamp} <= v;
  endtask

  task automatic randomize_status();
    logic [191:0] pool;
    int k;
    for (k = 0; k < 6; k++) pool[k*32 +: 32] = $random(seed);
    apply_status(pool[status_bits-1:0]);
  endtask

  // Back-to-back reads, then wait for every return
  task automatic read_burst(input int first, input int last);
    int a;
    for (a = first; a <= last; a++) begin
      @(posedge clk);
      rd_en    <= 1'b1;
      addr     <= 5'(a);
      exp_word <= pack_status(5'(a));
      exp_err  <= (a >= num_status_regs);
    end
    @(posedge clk);
    rd_en <= 1'b0;
    while (in_flight != 0) @(posedge clk);
  endtask

  task automatic write_reg(input logic [4:0] a, input logic [reg_width-1:0] d,
                           input logic with_read);
    int idx;
    @(posedge clk);
    wr_en <= 1'b1;
    rd_en <= with_read;  // Read dropped when paired
    addr  <= a;
    wdata <= d;
    @(posedge clk);
    wr_en <= 1'b0;
    rd_en <= 1'b0;
    repeat (2) @(posedge clk);  // Decode then counter
    if (a >= REG_DC_THRES && a <= REG_DO_COUNT) begin
      idx = counter_of(a);
      if (a[0]) begin
        m_thres[idx] = d;
        // Count already at the new threshold raises the flag
        if (d != '0 && m_count[idx] >= d) m_flag[idx] = 1'b1;
      end else begin
        m_count[idx] = '0;
        m_flag[idx]  = 1'b0;
      end
    end
  endtask

  task automatic pulse_events(input int idx, input int n);
    int i;
    for (i = 0; i < n; i++) begin
      @(posedge clk);
      ev_data_corrupt  <= (idx == 0);
      ev_unknown_ttc   <= (idx == 1);
      ev_ddr3_overflow <= (idx == 2);
    end
    @(posedge clk);
    {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow} <= 3'b000;
    repeat (2) @(posedge clk);  // Flag lags count by one edge
    m_count[idx] = m_count[idx] + 32'(n);
    if (m_thres[idx] != '0 && m_count[idx] >= m_thres[idx]) m_flag[idx] = 1'b1;
  endtask

  task automatic check_flags();
    @(posedge clk);
    flag_chk  <= 1'b1;
    exp_flags <= m_flag;
    @(posedge clk);
    flag_chk  <= 1'b0;
  endtask

  task automatic end_test(input string name);
    $display("test %-22s checks %0d errors %0d", name, n_checks - prev_checks,
             n_errors - prev_errors);
    prev_checks = n_checks;
    prev_errors = n_errors;
  endtask

  initial begin
    #(10 * (budget + 200));
    $display("Timeout: run did not finish, %0d reads still waiting for rd_valid", in_flight);
    $display("CHECKS FAILED");
    $finish;
  end

  initial begin
    seed = 32'hb5054255;
    {arst_n, wr_en, rd_en, addr, wdata, exp_word, exp_err, flag_chk, exp_flags} = '0;
    {ev_data_corrupt, ev_unknown_ttc, ev_ddr3_overflow, m_flag, prev_checks, prev_errors} = '0;
    m_count = '{3{'0}};
    m_thres = '{3{'0}};
    apply_status('0);
    repeat (3) @(posedge clk);
    arst_n <= 1'b1;

    read_burst(0, num_status_regs - 1);
    check_flags();
    end_test("reset values");

    randomize_status();
    read_burst(0, 12);  // Two reads in flight
    end_test("random status words");

    for (int i = 0; i < 3; i++) write_reg(5'(REG_DC_THRES + 2 * i), $random(seed), 1'b0);
    read_burst(REG_DC_THRES, REG_DO_COUNT);
    write_reg(REG_UT_THRES, $random(seed), 1'b1);
    read_burst(REG_UT_THRES, REG_UT_THRES);
    end_test("threshold writes");

    write_reg(REG_DC_THRES, 32'd3, 1'b0);
    write_reg(REG_UT_THRES, 32'd0, 1'b0);  // Zero threshold, never flags
    write_reg(REG_DO_THRES, 32'd5, 1'b0);
    pulse_events(0, 2);
    check_flags();
    read_burst(REG_ERROR, REG_ERROR);
    pulse_events(0, 1);
    pulse_events(1, 7);
    pulse_events(2, 6);
    check_flags();
    read_burst(REG_ERROR, REG_ERROR);
    read_burst(REG_DC_THRES, REG_DO_COUNT);
    end_test("event counting");

    write_reg(REG_UT_THRES, 32'd7, 1'b0);  // Count already at 7, flag follows
    write_reg(REG_DC_COUNT, $random(seed), 1'b0);
    write_reg(REG_DO_COUNT, $random(seed), 1'b0);
    check_flags();
    read_burst(REG_ERROR, REG_ERROR);
    read_burst(REG_DC_THRES, REG_DO_COUNT);
    end_test("count clear");

    read_burst(num_status_regs, 31);
    end_test("unmapped reads");

    $display("Summary: %0d checks, %0d errors, %0d assertion failures",
             n_checks, n_errors, dut0.u_assert.fail_count);
    if (n_errors == 0 && dut0.u_assert.fail_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- rider_status.f
rtl/rider_status_pkg.sv
rtl/reg_access_decode.sv
rtl/soft_error_counter.sv
rtl/status_reg_block.sv
rtl/rider_status.sv
bench/rider_status_assert.sv
bench/rider_status_checker.sv
bench/tb_rider_status.sv

//--- Makefile
TOP = tb_rider_status

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f rider_status.f
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "ALL CHECKS PASSED"

clean:
	rm -rf obj_dir
